// ==== sources.f ====
+incdir+include
hdl/seg_trail_pkg.sv
hdl/button_cond.sv
hdl/tick_gen.sv
hdl/cursor_nav.sv
hdl/trail_ctrl.sv
hdl/seg_render.sv
hdl/seg_trail_top.sv
verif/tb_seg_trail.sv

// ==== Bender.yml ====
package:
  name: seg_trail

sources:
  - include_dirs:
      - include
    files:
      - hdl/seg_trail_pkg.sv
      - hdl/button_cond.sv
      - hdl/tick_gen.sv
      - hdl/cursor_nav.sv
      - hdl/trail_ctrl.sv
      - hdl/seg_render.sv
      - hdl/seg_trail_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/tb_seg_trail.sv

// ==== verif/tb_seg_trail.sv ====
`timescale 1ns/10ps
`include "seg_trail_cfg.svh"

module tb_seg_trail import seg_trail_pkg::*; ();

    localparam int CYCLE_LIMIT = 4000;
    localparam int BTN_RIGHT = 0;
    localparam int BTN_LEFT  = 1;
    localparam int BTN_UP    = 2;
    localparam int BTN_DOWN  = 3;

    logic clk;
    logic rst;
    logic [3:0] btn;
    seg_vec_t seg_n;

    // Reference model registers
    logic [`DEBOUNCE_DEPTH-1:0] m_hist [4];
    logic [3:0] m_lvl_d;
    logic [3:0] m_press;
    int m_cnt;
    logic m_tick;
    logic m_half;
    int m_ticks;
    game_state_t m_state;
    logic m_empty_seen;
    seg_idx_t m_cursor;
    heading_t m_heading;
    seg_vec_t m_trail;
    logic m_blink;
    seg_vec_t m_seg;
    logic [4:0] nav_next;
    // Each row packs pos, heading, button, new pos and new heading
    logic [11:0] nav_rows [19];

    int seed;
    int pick;
    int cycles = 0;
    int checks = 0;
    int errors = 0;
    int settle_cycles = 0;
    bit watching = 0;
    bit returned = 0;

    seg_trail_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .btn_right (btn[BTN_RIGHT]),
        .btn_left  (btn[BTN_LEFT]),
        .btn_up    (btn[BTN_UP]),
        .btn_down  (btn[BTN_DOWN]),
        .seg_n     (seg_n)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [11:0] make_row(input seg_idx_t pos, input heading_t hd,
                                             input int b, input seg_idx_t npos,
                                             input heading_t nhd);
        return {pos, hd, 2'(b), npos, nhd};
    endfunction

    task automatic load_nav_table();
        nav_rows[0]  = make_row(SEG_A, HEAD_RIGHT, BTN_RIGHT, SEG_B, HEAD_DOWN);
        nav_rows[1]  = make_row(SEG_A, HEAD_LEFT,  BTN_LEFT,  SEG_F, HEAD_DOWN);
        nav_rows[2]  = make_row(SEG_B, HEAD_UP,    BTN_LEFT,  SEG_A, HEAD_LEFT);
        nav_rows[3]  = make_row(SEG_B, HEAD_DOWN,  BTN_RIGHT, SEG_G, HEAD_LEFT);
        nav_rows[4]  = make_row(SEG_B, HEAD_DOWN,  BTN_UP,    SEG_C, HEAD_DOWN);
        nav_rows[5]  = make_row(SEG_C, HEAD_UP,    BTN_LEFT,  SEG_G, HEAD_LEFT);
        nav_rows[6]  = make_row(SEG_C, HEAD_UP,    BTN_UP,    SEG_B, HEAD_UP);
        nav_rows[7]  = make_row(SEG_C, HEAD_DOWN,  BTN_RIGHT, SEG_D, HEAD_DOWN);
        nav_rows[8]  = make_row(SEG_D, HEAD_RIGHT, BTN_LEFT,  SEG_C, HEAD_UP);
        nav_rows[9]  = make_row(SEG_D, HEAD_LEFT,  BTN_RIGHT, SEG_E, HEAD_UP);
        nav_rows[10] = make_row(SEG_E, HEAD_UP,    BTN_RIGHT, SEG_G, HEAD_RIGHT);
        nav_rows[11] = make_row(SEG_E, HEAD_UP,    BTN_UP,    SEG_F, HEAD_UP);
        nav_rows[12] = make_row(SEG_E, HEAD_DOWN,  BTN_LEFT,  SEG_D, HEAD_RIGHT);
        nav_rows[13] = make_row(SEG_F, HEAD_UP,    BTN_RIGHT, SEG_A, HEAD_RIGHT);
        nav_rows[14] = make_row(SEG_F, HEAD_DOWN,  BTN_LEFT,  SEG_G, HEAD_RIGHT);
        nav_rows[15] = make_row(SEG_G, HEAD_RIGHT, BTN_LEFT,  SEG_B, HEAD_UP);
        nav_rows[16] = make_row(SEG_G, HEAD_RIGHT, BTN_RIGHT, SEG_C, HEAD_DOWN);
        nav_rows[17] = make_row(SEG_G, HEAD_LEFT,  BTN_LEFT,  SEG_E, HEAD_DOWN);
        nav_rows[18] = make_row(SEG_G, HEAD_LEFT,  BTN_RIGHT, SEG_F, HEAD_UP);
    endtask

    // First row in table order whose button is pressed wins
    function automatic logic [4:0] nav_step(input seg_idx_t pos, input heading_t hd,
                                            input logic [3:0] pr);
        logic [11:0] r;
        for (int i = 0; i < 19; i++) begin
            r = nav_rows[i];
            if (r[11:9] == pos && r[8:7] == hd && pr[r[6:5]]) begin
                return r[4:0];
            end
        end
        return {pos, hd};
    endfunction

    function automatic seg_vec_t display_pattern(input game_state_t st, input seg_vec_t tr,
                                                 input logic bl, input seg_idx_t cur);
        seg_vec_t cur_bit;
        cur_bit = seg_vec_t'(1) << cur;
        case (st)
            ST_WAIT:   return `SEG_ONLY_G;
            ST_MOVING: return ~cur_bit;
            default:   return ~(bl ? (tr ^ cur_bit) : tr);
        endcase
    endfunction

    always @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int b = 0; b < 4; b++) begin
                m_hist[b] <= '0;
            end
            m_lvl_d      <= '0;
            m_press      <= '0;
            m_cnt        <= 0;
            m_tick       <= 1'b0;
            m_half       <= 1'b0;
            m_ticks      <= 0;
            m_state      <= ST_WAIT;
            m_empty_seen <= 1'b0;
            m_cursor     <= SEG_G;
            m_heading    <= HEAD_LEFT;
            m_trail      <= '0;
            m_blink      <= 1'b0;
            m_seg        <= `SEG_ONLY_G;
        end else begin
            for (int b = 0; b < 4; b++) begin
                m_hist[b]  <= {m_hist[b][`DEBOUNCE_DEPTH-2:0], btn[b]};
                m_lvl_d[b] <= &m_hist[b];
                m_press[b] <= (&m_hist[b]) & ~m_lvl_d[b];
            end
            m_cnt  <= (m_cnt == `TICK_CYCLES - 1) ? 0 : m_cnt + 1;
            m_tick <= (m_cnt == `TICK_CYCLES - 1);
            m_half <= (m_cnt == `TICK_CYCLES - 1) || (m_cnt == `TICK_CYCLES / 2 - 1);
            m_empty_seen <= (m_state == ST_ERASING) && (m_empty_seen || m_trail == '0);
            case (m_state)
                ST_WAIT: begin
                    if (m_tick && m_ticks == `WAIT_TICKS - 1) begin
                        m_state <= ST_MOVING;
                        m_ticks <= 0;
                    end else if (m_tick) begin
                        m_ticks <= m_ticks + 1;
                    end
                end
                ST_MOVING: begin
                    if (m_press[BTN_DOWN]) begin
                        m_state <= ST_ERASING;
                        m_trail <= '1;
                    end
                end
                default: begin
                    m_trail[m_cursor] <= 1'b0;
                    if (m_empty_seen && m_half)
                        m_state <= ST_WAIT;
                end
            endcase
            nav_next = nav_step(m_cursor, m_heading, m_press);
            m_cursor  <= (m_state == ST_WAIT) ? SEG_G : nav_next[4:2];
            m_heading <= (m_state == ST_WAIT) ? HEAD_LEFT : heading_t'(nav_next[1:0]);
            m_blink   <= (m_state == ST_ERASING) && (m_blink ^ m_half);
            m_seg     <= display_pattern(m_state, m_trail, m_blink, m_cursor);
        end
    end

    always @(negedge clk) begin
        if (!rst) begin
            checks++;
            assert (seg_n === m_seg) else begin
                errors++;
                $display("ERROR at %0t: seg_n expected %b, got %b", $time, m_seg, seg_n);
            end
            if (watching) begin
                settle_cycles++;
                if (seg_n === `SEG_ONLY_G) begin
                    checks++;
                    assert (settle_cycles <= `TICK_CYCLES / 2 + 2) else begin
                        errors++;
                        $display("Display needed %0d cycles to return home after the trail emptied",
                                 settle_cycles);
                    end
                    watching = 0;
                    returned = 1;
                end
            end else if (m_state == ST_ERASING && m_trail == '0) begin
                watching = 1;
                settle_cycles = 0;
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Run stopped after %0d cycles without finishing the stimulus", cycles);
            $display("Something failed");
            $finish;
        end
    end

    task automatic reset_dut();
        rst = 1'b1;
        repeat (2) @(posedge clk);
        #5;
        rst = 1'b0;
    endtask

    task automatic press_button(input int idx);
        btn[idx] = 1'b1;
        repeat (8) @(posedge clk);
        #5;
        btn[idx] = 1'b0;
        repeat (10) @(posedge clk);
        #5;
    endtask

    // Too short for the debouncer
    task automatic glitch_button(input int idx);
        btn[idx] = 1'b1;
        repeat (2) @(posedge clk);
        #5;
        btn[idx] = 1'b0;
        repeat (8) @(posedge clk);
        #5;
    endtask

    task automatic wait_for_state(input game_state_t st);
        while (m_state != st) begin
            @(posedge clk);
            #5;
        end
    endtask

    initial begin
        btn = '0;
        rst = 1'b1;
        seed = 32'h06b3847e;
        load_nav_table();
        reset_dut();
        // Presses while waiting must not disturb the home pattern
        press_button(BTN_RIGHT);
        press_button(BTN_DOWN);
        wait_for_state(ST_MOVING);
        glitch_button(BTN_RIGHT);
        glitch_button(BTN_LEFT);
        for (int i = 0; i < 40; i++) begin
            pick = $unsigned($random(seed)) % 3;
            press_button(pick);
            // D heading down has no way out and needs a restart
            if (m_cursor == SEG_D && m_heading == HEAD_DOWN) begin
                reset_dut();
                wait_for_state(ST_MOVING);
            end
        end
        reset_dut();
        wait_for_state(ST_MOVING);
        press_button(BTN_DOWN);
        // Erasing lights every outer segment while the cursor sits on G
        checks++;
        assert (seg_n[5:0] === 6'b000000) else begin
            errors++;
            $display("ERROR at %0t: seg_n[5:0] expected %b, got %b", $time, 6'b000000,
                     seg_n[5:0]);
        end
        // Steer from G through E D C B A F around the figure eight
        press_button(BTN_LEFT);
        press_button(BTN_LEFT);
        press_button(BTN_LEFT);
        press_button(BTN_UP);
        press_button(BTN_LEFT);
        press_button(BTN_LEFT);
        wait_for_state(ST_WAIT);
        repeat (4) @(posedge clk);
        #5;
        checks++;
        assert (returned) else begin
            errors++;
            $display("The trail never emptied, so the return to the home pattern was not seen");
        end
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

// ==== hdl/seg_trail_top.sv ====
`timescale 1ns/10ps

module seg_trail_top import seg_trail_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     btn_right,
    input  logic     btn_left,
    input  logic     btn_up,
    input  logic     btn_down,
    output seg_vec_t seg_n
);

    logic press_right;
    logic press_left;
    logic press_up;
    logic press_down;
    logic tick;
    logic half_tick;
    logic home;
    logic move_en;
    logic fill_trail;
    logic erasing;
    logic trail_empty;
    seg_idx_t cursor;

    button_cond btn_right0 (
        .clk   (clk),
        .rst   (rst),
        .btn   (btn_right),
        .press (press_right)
    );

    button_cond btn_left0 (
        .clk   (clk),
        .rst   (rst),
        .btn   (btn_left),
        .press (press_left)
    );

    button_cond btn_up0 (
        .clk   (clk),
        .rst   (rst),
        .btn   (btn_up),
        .press (press_up)
    );

    button_cond btn_down0 (
        .clk   (clk),
        .rst   (rst),
        .btn   (btn_down),
        .press (press_down)
    );

    tick_gen tick_gen0 (
        .clk       (clk),
        .rst       (rst),
        .tick      (tick),
        .half_tick (half_tick)
    );

    trail_ctrl trail_ctrl0 (
        .clk         (clk),
        .rst         (rst),
        .tick        (tick),
        .half_tick   (half_tick),
        .press_down  (press_down),
        .trail_empty (trail_empty),
        .home        (home),
        .move_en     (move_en),
        .fill_trail  (fill_trail),
        .erasing     (erasing)
    );

    // Down only drives the game state and not the cursor
    cursor_nav cursor_nav0 (
        .clk         (clk),
        .rst         (rst),
        .home        (home),
        .move_en     (move_en),
        .press_right (press_right),
        .press_left  (press_left),
        .press_up    (press_up),
        .cursor      (cursor),
        .heading     ()
    );

    seg_render seg_render0 (
        .clk         (clk),
        .rst         (rst),
        .home        (home),
        .erasing     (erasing),
        .fill_trail  (fill_trail),
        .half_tick   (half_tick),
        .cursor      (cursor),
        .trail_empty (trail_empty),
        .seg_n       (seg_n)
    );

endmodule

// ==== hdl/seg_render.sv ====
`timescale 1ns/10ps
`include "seg_trail_cfg.svh"

module seg_render import seg_trail_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     home,
    input  logic     erasing,
    input  logic     fill_trail,
    input  logic     half_tick,
    input  seg_idx_t cursor,
    output logic     trail_empty,
    output seg_vec_t seg_n
);

    seg_vec_t trail;
    seg_vec_t lit;
    seg_vec_t seg_next;
    logic blink_phase;

    assign trail_empty = (trail == '0);

    always_comb begin
        lit = trail;
        if (blink_phase) begin
            lit[cursor] = ~trail[cursor];
        end
        if (home) begin
            seg_next = `SEG_ONLY_G;
        end else if (erasing) begin
            seg_next = ~lit;
        end else begin
            // Moving shows the cursor alone
            seg_next = `SEG_ALL_OFF;
            seg_next[cursor] = 1'b0;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            trail       <= '0;
            blink_phase <= 1'b0;
            seg_n       <= `SEG_ONLY_G;
        end else begin
            if (fill_trail) begin
                trail <= '1;
            end else if (erasing) begin
                trail[cursor] <= 1'b0;
            end
            if (!erasing) begin
                blink_phase <= 1'b0;
            end else if (half_tick) begin
                blink_phase <= ~blink_phase;
            end
            seg_n <= seg_next;
        end
    end

endmodule

// ==== hdl/trail_ctrl.sv ====
`timescale 1ns/10ps
`include "seg_trail_cfg.svh"

module trail_ctrl import seg_trail_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic tick,
    input  logic half_tick,
    input  logic press_down,
    input  logic trail_empty,
    output logic home,
    output logic move_en,
    output logic fill_trail,
    output logic erasing
);

    localparam int WAIT_W = $clog2(`WAIT_TICKS + 1);
    localparam logic [WAIT_W-1:0] WAIT_LAST = WAIT_W'(`WAIT_TICKS - 1);

    game_state_t state;
    game_state_t state_next;
    logic [WAIT_W-1:0] wait_cnt;
    logic empty_seen;

    always_comb begin
        state_next = state;
        case (state)
            ST_WAIT: begin
                if (tick && wait_cnt == WAIT_LAST) begin
                    state_next = ST_MOVING;
                end
            end
            ST_MOVING: begin
                if (press_down) begin
                    state_next = ST_ERASING;
                end
            end
            ST_ERASING: begin
                // Leave on the first half tick after the trail ran out
                if (empty_seen && half_tick) begin
                    state_next = ST_WAIT;
                end
            end
            default: begin
                state_next = ST_WAIT;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= ST_WAIT;
            wait_cnt   <= '0;
            empty_seen <= 1'b0;
        end else begin
            state <= state_next;
            if (state != ST_WAIT) begin
                wait_cnt <= '0;
            end else if (tick) begin
                wait_cnt <= (wait_cnt == WAIT_LAST) ? '0 : wait_cnt + 1'b1;
            end
            empty_seen <= (state == ST_ERASING) && (empty_seen || trail_empty);
        end
    end

    assign home       = (state == ST_WAIT);
    assign move_en    = (state == ST_MOVING) || (state == ST_ERASING);
    assign erasing    = (state == ST_ERASING);
    // Trail loads at the same edge that enters erasing
    assign fill_trail = (state == ST_MOVING) && press_down;

endmodule

// ==== hdl/cursor_nav.sv ====
`timescale 1ns/10ps

module cursor_nav import seg_trail_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     home,
    input  logic     move_en,
    input  logic     press_right,
    input  logic     press_left,
    input  logic     press_up,
    output seg_idx_t cursor,
    output heading_t heading
);

    seg_idx_t cursor_next;
    heading_t heading_next;

    // Navigation table, first matching row wins
    always_comb begin
        cursor_next  = cursor;
        heading_next = heading;
        case (cursor)
            SEG_A: begin
                if (heading == HEAD_RIGHT && press_right) begin
                    cursor_next  = SEG_B;
                    heading_next = HEAD_DOWN;
                end else if (heading == HEAD_LEFT && press_left) begin
                    cursor_next  = SEG_F;
                    heading_next = HEAD_DOWN;
                end
            end
            SEG_B: begin
                if (heading == HEAD_UP && press_left) begin
                    cursor_next  = SEG_A;
                    heading_next = HEAD_LEFT;
                end else if (heading == HEAD_DOWN && press_right) begin
                    cursor_next  = SEG_G;
                    heading_next = HEAD_LEFT;
                end else if (heading == HEAD_DOWN && press_up) begin
                    cursor_next  = SEG_C;
                    heading_next = HEAD_DOWN;
                end
            end
            SEG_C: begin
                if (heading == HEAD_UP && press_left) begin
                    cursor_next  = SEG_G;
                    heading_next = HEAD_LEFT;
                end else if (heading == HEAD_UP && press_up) begin
                    cursor_next  = SEG_B;
                    heading_next = HEAD_UP;
                end else if (heading == HEAD_DOWN && press_right) begin
                    cursor_next  = SEG_D;
                    heading_next = HEAD_DOWN;
                end
            end
            SEG_D: begin
                if (heading == HEAD_RIGHT && press_left) begin
                    cursor_next  = SEG_C;
                    heading_next = HEAD_UP;
                end else if (heading == HEAD_LEFT && press_right) begin
                    cursor_next  = SEG_E;
                    heading_next = HEAD_UP;
                end
            end
            SEG_E: begin
                if (heading == HEAD_UP && press_right) begin
                    cursor_next  = SEG_G;
                    heading_next = HEAD_RIGHT;
                end else if (heading == HEAD_UP && press_up) begin
                    cursor_next  = SEG_F;
                    heading_next = HEAD_UP;
                end else if (heading == HEAD_DOWN && press_left) begin
                    cursor_next  = SEG_D;
                    heading_next = HEAD_RIGHT;
                end
            end
            SEG_F: begin
                if (heading == HEAD_UP && press_right) begin
                    cursor_next  = SEG_A;
                    heading_next = HEAD_RIGHT;
                end else if (heading == HEAD_DOWN && press_left) begin
                    cursor_next  = SEG_G;
                    heading_next = HEAD_RIGHT;
                end
            end
            SEG_G: begin
                if (heading == HEAD_RIGHT && press_left) begin
                    cursor_next  = SEG_B;
                    heading_next = HEAD_UP;
                end else if (heading == HEAD_RIGHT && press_right) begin
                    cursor_next  = SEG_C;
                    heading_next = HEAD_DOWN;
                end else if (heading == HEAD_LEFT && press_left) begin
                    cursor_next  = SEG_E;
                    heading_next = HEAD_DOWN;
                end else if (heading == HEAD_LEFT && press_right) begin
                    cursor_next  = SEG_F;
                    heading_next = HEAD_UP;
                end
            end
            default: begin
                cursor_next  = SEG_G;
                heading_next = HEAD_LEFT;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cursor  <= SEG_G;
            heading <= HEAD_LEFT;
        end else if (home) begin
            // Parked on the middle bar, facing left
            cursor  <= SEG_G;
            heading <= HEAD_LEFT;
        end else if (move_en) begin
            cursor  <= cursor_next;
            heading <= heading_next;
        end
    end

endmodule

// ==== hdl/tick_gen.sv ====
`timescale 1ns/10ps
`include "seg_trail_cfg.svh"

module tick_gen (
    input  logic clk,
    input  logic rst,
    output logic tick,
    output logic half_tick
);

    localparam int CNT_W = $clog2(`TICK_CYCLES);
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(`TICK_CYCLES - 1);
    localparam logic [CNT_W-1:0] CNT_MID  = CNT_W'(`TICK_CYCLES / 2 - 1);

    logic [CNT_W-1:0] count;
    logic at_last;
    logic at_mid;

    assign at_last = (count == CNT_LAST);
    assign at_mid  = (count == CNT_MID);

    // Free-running period counter
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            count <= '0;
        end else if (at_last) begin
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

    // Registered strobes; half tick lines up with tick at the period end
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tick      <= 1'b0;
            half_tick <= 1'b0;
        end else begin
            tick      <= at_last;
            half_tick <= at_last | at_mid;
        end
    end

endmodule

// ==== hdl/button_cond.sv ====
`timescale 1ns/10ps
`include "seg_trail_cfg.svh"

module button_cond (
    input  logic clk,
    input  logic rst,
    input  logic btn,
    output logic press
);

    logic [`DEBOUNCE_DEPTH-1:0] samples;
    logic level;
    logic level_d;

    // Debounced level needs a full run of high samples
    assign level = &samples;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            samples <= '0;
            level_d <= 1'b0;
            press   <= 1'b0;
        end else begin
            samples <= {samples[`DEBOUNCE_DEPTH-2:0], btn};
            level_d <= level;
            // Rising edge of the level, so a held button fires once
            press   <= level & ~level_d;
        end
    end

endmodule

// ==== hdl/seg_trail_pkg.sv ====
package seg_trail_pkg;

    // Segment index, A=0 through G=6
    typedef logic [2:0] seg_idx_t;

    // One bit per segment, A at bit 0
    typedef logic [6:0] seg_vec_t;

    localparam seg_idx_t SEG_A = 3'd0;
    localparam seg_idx_t SEG_B = 3'd1;
    localparam seg_idx_t SEG_C = 3'd2;
    localparam seg_idx_t SEG_D = 3'd3;
    localparam seg_idx_t SEG_E = 3'd4;
    localparam seg_idx_t SEG_F = 3'd5;
    localparam seg_idx_t SEG_G = 3'd6;

    typedef enum logic [1:0] {
        HEAD_RIGHT,
        HEAD_LEFT,
        HEAD_UP,
        HEAD_DOWN
    } heading_t;

    typedef enum logic [1:0] {
        ST_WAIT,
        ST_MOVING,
        ST_ERASING
    } game_state_t;

endpackage

// ==== include/seg_trail_cfg.svh ====
`ifndef SEG_TRAIL_CFG_SVH
`define SEG_TRAIL_CFG_SVH

// Consecutive high samples that count as a press
`define DEBOUNCE_DEPTH 4

// clk cycles per slow tick, kept short for simulation
`define TICK_CYCLES 16

// Slow ticks spent showing the home pattern
`define WAIT_TICKS 3

// Active-low display patterns, segment A at bit 0
`define SEG_ALL_OFF 7'b1111111
`define SEG_ONLY_G  7'b0111111

`endif
